/* files.f */
+incdir+hdl
hdl/icache_pkg.sv
hdl/ic_sram.sv
hdl/ic_way_array.sv
hdl/ic_fetch_pipe.sv
hdl/ic_refill_ctrl.sv
hdl/icache_top.sv
tests/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f files.f --top-module tb_icache -o tb_icache_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_icache_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
   exit 1
fi
exit 0

/* tests/tb_icache.sv */
// Cache testbench; random traffic keeps one line tag per set because payload writes hit every way
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
   import icache_pkg::*;

   localparam paddr_t ADDR_A    = 32'h0001_2348;
   localparam paddr_t ADDR_B    = 32'h0003_4560;   // Never filled
   localparam paddr_t IDLE_ADDR = 32'h0000_0000;

   logic   clk = 1'b0;
   logic   rst_i;
   vpo_t   vpo_i;
   ppn_t   ppn_s2_i;
   logic   kill_req_s2_i;
   logic   stall_req_o;
   fetch_t ins_o;
   logic   valid_o;
   logic   op_inv_i;
   paddr_t op_inv_paddr_i;
   logic   op_stall_req_o;
   logic   axi_ar_ready_i;
   logic   axi_ar_valid_o;
   paddr_t axi_ar_addr_o;
   logic   axi_r_ready_o;
   logic   axi_r_valid_i;
   fetch_t axi_r_data_i;
   logic   axi_r_last_i;

   int     err_cnt = 0;
   int     to_cnt = 0;
   int     cyc = 0;
   int     stall_cnt = 0;
   int     ar_count = 0;
   paddr_t ar_addr_seen;
   logic   lat_chk = 1'b0;

   // Fetch requests waiting, the one in stage 1, and those expected on valid_o
   paddr_t req_addr_q[$];
   logic   req_kill_q[$];
   paddr_t cur_addr = IDLE_ADDR;
   logic   cur_kill = 1'b1;
   int     cur_cyc = 0;
   paddr_t exp_addr_q[$];
   int     exp_cyc_q[$];

   icache_top UUT
      (
         .clk            (clk),
         .rst_i          (rst_i),
         .vpo_i          (vpo_i),
         .ppn_s2_i       (ppn_s2_i),
         .kill_req_s2_i  (kill_req_s2_i),
         .stall_req_o    (stall_req_o),
         .ins_o          (ins_o),
         .valid_o        (valid_o),
         .op_inv_i       (op_inv_i),
         .op_inv_paddr_i (op_inv_paddr_i),
         .op_stall_req_o (op_stall_req_o),
         .axi_ar_ready_i (axi_ar_ready_i),
         .axi_ar_valid_o (axi_ar_valid_o),
         .axi_ar_addr_o  (axi_ar_addr_o),
         .axi_r_ready_o  (axi_r_ready_o),
         .axi_r_valid_i  (axi_r_valid_i),
         .axi_r_data_i   (axi_r_data_i),
         .axi_r_last_i   (axi_r_last_i)
      );

   always #20 clk = ~clk;

   always @(posedge clk)
      cyc <= cyc + 1;

   // Memory contents as a mix of the 8-byte aligned address
   function automatic fetch_t mem_word(input paddr_t addr);
      paddr_t a;
      begin
         a = {addr[31:3], 3'b000};
         return {(a * 32'h9E37_79B1) ^ 32'hA5A5_5A5A, {a[15:0], a[31:16]} ^ ~a};
      end
   endfunction

   // Stage-2 PPN for the fetch in stage 1, then the next vpo
   always @(negedge clk)
      begin
         if (!rst_i && !stall_req_o)
            begin
               ppn_s2_i      = cur_addr[31:12];
               kill_req_s2_i = cur_kill;
               if (!cur_kill)
                  begin
                     exp_addr_q.push_back(cur_addr);
                     exp_cyc_q.push_back(cur_cyc);
                  end
               if (req_addr_q.size() > 0)
                  begin
                     cur_addr = req_addr_q.pop_front();
                     cur_kill = req_kill_q.pop_front();
                  end
               else
                  begin
                     cur_addr = IDLE_ADDR;
                     cur_kill = 1'b1;   // Filler that never shows on valid_o
                  end
               cur_cyc = cyc;
               vpo_i   = cur_addr[11:0];
            end
      end

   // AXI memory model, 0 idle, 1 delay before ready, 2 accepted, 3 beats
   always @(negedge clk)
      begin : responder
         int rsp_st;
         int delay;
         int gap;
         int beat;
         if (rst_i)
            begin
               rsp_st = 0;
               axi_ar_ready_i = 1'b0;
               axi_r_valid_i  = 1'b0;
               axi_r_last_i   = 1'b0;
            end
         else
            begin
               axi_ar_ready_i = 1'b0;
               axi_r_valid_i  = 1'b0;
               axi_r_last_i   = 1'b0;
               case (rsp_st)
                  0:
                     if (axi_ar_valid_o)
                        begin
                           ar_addr_seen = axi_ar_addr_o;
                           ar_count++;
                           assert (axi_ar_addr_o[4:0] == 5'd0)
                              else begin
                                 $display("ERROR at %0t ns: axi_ar_addr_o = %h, expected %h",
                                          $time, axi_ar_addr_o, {axi_ar_addr_o[31:5], 5'd0});
                                 err_cnt++;
                              end
                           delay  = $urandom % 4;
                           rsp_st = 1;
                        end
                  1:
                     begin
                        assert (axi_ar_valid_o && axi_ar_addr_o == ar_addr_seen)
                           else begin
                              $display("AR request changed at %0t ns before it was accepted",
                                       $time);
                              err_cnt++;
                           end
                        if (delay == 0)
                           begin
                              axi_ar_ready_i = 1'b1;
                              rsp_st = 2;
                           end
                        else
                           delay--;
                     end
                  2:
                     begin
                        beat   = 0;
                        gap    = $urandom % 3;
                        rsp_st = 3;
                     end
                  default:
                     if (gap != 0)
                        gap--;
                     else
                        begin
                           assert (axi_r_ready_o)
                              else begin
                                 $display("axi_r_ready_o low during refill at %0t ns", $time);
                                 err_cnt++;
                              end
                           axi_r_valid_i = 1'b1;
                           axi_r_data_i  = mem_word(ar_addr_seen + paddr_t'(beat * 8));
                           axi_r_last_i  = (beat == 3);
                           beat++;
                           gap = $urandom % 3;
                           if (beat == 4)
                              rsp_st = 0;
                        end
               endcase
            end
      end

   // Compares every delivered window with the memory model
   always @(negedge clk)
      begin : compare_window
         paddr_t a;
         int     c;
         fetch_t exp_w;
         if (!rst_i)
            begin
               if (stall_req_o)
                  stall_cnt++;
               if (valid_o)
                  begin
                     assert (exp_addr_q.size() != 0)
                        else begin
                           $display("valid_o high at %0t ns with no fetch outstanding", $time);
                           err_cnt++;
                        end
                     if (exp_addr_q.size() != 0)
                        begin
                           a = exp_addr_q.pop_front();
                           c = exp_cyc_q.pop_front();
                           exp_w = mem_word(a);
                           assert (ins_o === exp_w)
                              else begin
                                 $display("ERROR at %0t ns: ins_o = %h, expected %h (addr %h)",
                                          $time, ins_o, exp_w, a);
                                 err_cnt++;
                              end
                           if (lat_chk)
                              begin
                                 assert (cyc - c == 2)
                                    else begin
                                       $display("ERROR at %0t ns: valid_o latency = %0d, expected 2",
                                                $time, cyc - c);
                                       err_cnt++;
                                    end
                              end
                        end
                  end
            end
      end

   task automatic push_fetch(input paddr_t addr, input logic kill);
      begin
         req_addr_q.push_back(addr);
         req_kill_q.push_back(kill);
      end
   endtask

   // True once every queued fetch has come out and the cache is idle
   function automatic logic fetches_done();
      return req_addr_q.size() == 0 && cur_kill && exp_addr_q.size() == 0 && !stall_req_o;
   endfunction

   task automatic wait_drain(input int limit);
      int n;
      begin
         n = 0;
         while (n < limit && !fetches_done())
            begin
               @(negedge clk);
               #1;
               n++;
            end
         if (!fetches_done())
            begin
               $display("Timeout at %0t ns: fetches not done after %0d cycles", $time, limit);
               to_cnt++;
            end
      end
   endtask

   task automatic invalidate_line(input paddr_t addr);
      begin
         repeat (2) @(negedge clk);   // Only filler fetches in the pipe
         assert (!stall_req_o)
            else begin
               $display("Cache busy when the invalidate was issued at %0t ns", $time);
               err_cnt++;
            end
         op_inv_i       = 1'b1;
         op_inv_paddr_i = addr;
         #1;
         assert (op_stall_req_o)
            else begin
               $display("ERROR at %0t ns: op_stall_req_o = 0, expected 1", $time);
               err_cnt++;
            end
         @(negedge clk);
         op_inv_i = 1'b0;
         #1;
         assert (stall_req_o)
            else begin
               $display("ERROR at %0t ns: stall_req_o = 0, expected 1", $time);
               err_cnt++;
            end
      end
   endtask

   initial
      begin : main
         int     n;
         int     ar0;
         int     st0;
         logic [31:0] r;
         ppn_t   p;
         void'($urandom(32'hede2));
         rst_i          = 1'b1;
         vpo_i          = '0;
         ppn_s2_i       = '0;
         kill_req_s2_i  = 1'b1;
         op_inv_i       = 1'b0;
         op_inv_paddr_i = '0;
         axi_ar_ready_i = 1'b0;
         axi_r_valid_i  = 1'b0;
         axi_r_data_i   = '0;
         axi_r_last_i   = 1'b0;

         // Reset and boot clear
         repeat (10)
            begin
               @(negedge clk);
               assert (!axi_ar_valid_o && !axi_r_ready_o && !valid_o)
                  else begin
                     $display("AXI request or valid_o active during reset at %0t ns", $time);
                     err_cnt++;
                  end
            end
         rst_i = 1'b0;
         #1;
         assert (stall_req_o)
            else begin
               $display("ERROR at %0t ns: stall_req_o = 0, expected 1", $time);
               err_cnt++;
            end
         n = 0;
         while (stall_req_o && n < 40)
            begin
               assert (!axi_ar_valid_o && !axi_r_ready_o && !valid_o)
                  else begin
                     $display("AXI request or valid_o active during boot at %0t ns", $time);
                     err_cnt++;
                  end
               @(negedge clk);
               #1;
               n++;
            end
         if (stall_req_o)
            begin
               $display("Timeout: boot did not end within 40 cycles");
               to_cnt++;
            end

         // Miss and refill
         ar0 = ar_count;
         push_fetch(ADDR_A, 1'b0);
         wait_drain(100);
         assert (ar_count == ar0 + 1 && ar_addr_seen == {ADDR_A[31:5], 5'd0})
            else begin
               $display("ERROR at %0t ns: axi_ar_addr_o = %h, expected %h",
                        $time, ar_addr_seen, {ADDR_A[31:5], 5'd0});
               err_cnt++;
            end

         // Hits on the other windows of the filled line
         ar0     = ar_count;
         lat_chk = 1'b1;
         for (int w = 0; w < 4; w++)
            push_fetch({ADDR_A[31:5], 5'd0} + paddr_t'(w * 8), 1'b0);
         wait_drain(50);
         lat_chk = 1'b0;
         assert (ar_count == ar0)
            else begin
               $display("AR request raised for a line that should hit");
               err_cnt++;
            end

         // Killed miss
         ar0 = ar_count;
         st0 = stall_cnt;
         push_fetch(ADDR_B, 1'b1);
         wait_drain(50);
         repeat (4) @(negedge clk);
         #1;
         assert (ar_count == ar0 && stall_cnt == st0)
            else begin
               $display("Killed fetch caused a refill or a stall at %0t ns", $time);
               err_cnt++;
            end

         // Invalidate then refetch
         invalidate_line(ADDR_A);
         wait_drain(20);
         ar0 = ar_count;
         push_fetch(ADDR_A, 1'b0);
         wait_drain(100);
         assert (ar_count == ar0 + 1)
            else begin
               $display("Fetch after invalidate did not refill the line");
               err_cnt++;
            end

         // Random traffic, set bits 3:2 follow the PPN
         for (int i = 0; i < 60; i++)
            begin
               r = $urandom;
               p = 20'h10 + ppn_t'(r[1:0]);
               push_fetch({p, 3'b000, p[1:0], r[5:4], r[12:8]}, r[31:29] == 3'd0);
            end
         wait_drain(3000);

         $display("Summary: %0d check errors, %0d timeouts", err_cnt, to_cnt);
         if (err_cnt == 0 && to_cnt == 0)
            $display("PASS: all tests");
         else
            $display("FAIL: see errors above");
         $finish;
      end

endmodule

`default_nettype wire

/* hdl/icache_top.sv */
// Instruction cache top; fetch side must hold vpo_i and ppn_s2_i while stall_req_o is high
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_top
(
   input  logic                  clk,
   input  logic                  rst_i,
   // Fetch side
   input  icache_pkg::vpo_t      vpo_i,
   input  icache_pkg::ppn_t      ppn_s2_i,
   input  logic                  kill_req_s2_i,
   output logic                  stall_req_o,
   output icache_pkg::fetch_t    ins_o,
   output logic                  valid_o,
   // Invalidate
   input  logic                  op_inv_i,
   input  icache_pkg::paddr_t    op_inv_paddr_i,
   output logic                  op_stall_req_o,
   // AXI read channels
   input  logic                  axi_ar_ready_i,
   output logic                  axi_ar_valid_o,
   output icache_pkg::paddr_t    axi_ar_addr_o,
   output logic                  axi_r_ready_o,
   input  logic                  axi_r_valid_i,
   input  icache_pkg::fetch_t    axi_r_data_i,
   input  logic                  axi_r_last_i
);
   import icache_pkg::*;

   logic                       rd_en;
   set_idx_t                   line_addr;
   payload_addr_t              payload_addr;
   logic [(1<<`IC_P_WAYS)-1:0] tag_we;
   tag_t                       tag_wdata;
   logic                       tag_valid_wdata;
   logic                       payload_we;
   fetch_t                     payload_wdata;
   logic                       refill_beat;
   line_off_t                  refill_off;
   paddr_t                     s2_paddr;
   logic                       miss;
   logic                       hit;
   fetch_t                     hit_data;
   tag_t                       cmp_tag;

   ic_refill_ctrl u_ctrl
      (
         .clk               (clk),
         .rst_i             (rst_i),
         .vpo_i             (vpo_i),
         .op_inv_i          (op_inv_i),
         .op_inv_paddr_i    (op_inv_paddr_i),
         .miss_i            (miss),
         .s2_paddr_i        (s2_paddr),
         .axi_ar_ready_i    (axi_ar_ready_i),
         .axi_r_valid_i     (axi_r_valid_i),
         .axi_r_data_i      (axi_r_data_i),
         .axi_r_last_i      (axi_r_last_i),
         .stall_o           (stall_req_o),
         .op_stall_req_o    (op_stall_req_o),
         .rd_en_o           (rd_en),
         .line_addr_o       (line_addr),
         .payload_addr_o    (payload_addr),
         .tag_we_o          (tag_we),
         .tag_wdata_o       (tag_wdata),
         .tag_valid_wdata_o (tag_valid_wdata),
         .payload_we_o      (payload_we),
         .payload_wdata_o   (payload_wdata),
         .refill_beat_o     (refill_beat),
         .refill_off_o      (refill_off),
         .axi_ar_valid_o    (axi_ar_valid_o),
         .axi_ar_addr_o     (axi_ar_addr_o),
         .axi_r_ready_o     (axi_r_ready_o)
      );

   ic_way_array u_ways
      (
         .clk               (clk),
         .rd_en_i           (rd_en),
         .line_addr_i       (line_addr),
         .payload_addr_i    (payload_addr),
         .tag_we_i          (tag_we),
         .tag_wdata_i       (tag_wdata),
         .tag_valid_wdata_i (tag_valid_wdata),
         .payload_we_i      (payload_we),
         .payload_wdata_i   (payload_wdata),
         .cmp_tag_i         (cmp_tag),
         .hit_o             (hit),
         .hit_data_o        (hit_data)
      );

   // Bus beat doubles as the bypass data
   ic_fetch_pipe u_pipe
      (
         .clk               (clk),
         .rst_i             (rst_i),
         .stall_i           (stall_req_o),
         .vpo_i             (vpo_i),
         .ppn_s2_i          (ppn_s2_i),
         .kill_req_s2_i     (kill_req_s2_i),
         .hit_i             (hit),
         .hit_data_i        (hit_data),
         .refill_beat_i     (refill_beat),
         .refill_off_i      (refill_off),
         .refill_data_i     (payload_wdata),
         .s2_paddr_o        (s2_paddr),
         .cmp_tag_o         (cmp_tag),
         .miss_o            (miss),
         .ins_o             (ins_o),
         .valid_o           (valid_o)
      );

endmodule

`default_nettype wire

/* hdl/ic_refill_ctrl.sv */
// Cache FSM and AXI AR/R master; one outstanding burst, R beats assumed in order with last on beat 4
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module ic_refill_ctrl
(
   input  logic                        clk,
   input  logic                        rst_i,
   input  icache_pkg::vpo_t            vpo_i,
   input  logic                        op_inv_i,
   input  icache_pkg::paddr_t          op_inv_paddr_i,
   input  logic                        miss_i,
   input  icache_pkg::paddr_t          s2_paddr_i,
   input  logic                        axi_ar_ready_i,
   input  logic                        axi_r_valid_i,
   input  icache_pkg::fetch_t          axi_r_data_i,
   input  logic                        axi_r_last_i,
   output logic                        stall_o,
   output logic                        op_stall_req_o,
   output logic                        rd_en_o,
   output icache_pkg::set_idx_t        line_addr_o,
   output icache_pkg::payload_addr_t   payload_addr_o,
   output logic [(1<<`IC_P_WAYS)-1:0]  tag_we_o,
   output icache_pkg::tag_t            tag_wdata_o,
   output logic                        tag_valid_wdata_o,
   output logic                        payload_we_o,
   output icache_pkg::fetch_t          payload_wdata_o,
   output logic                        refill_beat_o,
   output icache_pkg::line_off_t       refill_off_o,
   output logic                        axi_ar_valid_o,
   output icache_pkg::paddr_t          axi_ar_addr_o,
   output logic                        axi_r_ready_o
);
   import icache_pkg::*;

   localparam int        NWAYS      = 1 << `IC_P_WAYS;
   localparam int        TAG_LSB    = `IC_P_SETS + `IC_P_LINE;
   localparam int        WIN_BITS   = `IC_P_LINE - `IC_P_FETCH_BYTES;
   localparam line_off_t BEAT_BYTES = line_off_t'((1 << `IC_P_LINE) / `IC_BEATS);

   ic_state_t     state_q;
   ic_state_t     state_d;
   set_idx_t      boot_cnt_q;
   way_idx_t      free_way_q;
   line_off_t     refill_cnt_q;
   set_idx_t      inv_set_q;
   set_idx_t      s1_line_q;
   payload_addr_t s1_payload_q;
   set_idx_t      s2_set;
   logic          r_hds;
   logic          r_hds_last;
   logic          ar_set;
   logic          ar_clr;

   assign s2_set     = s2_paddr_i[`IC_P_LINE +: `IC_P_SETS];
   assign r_hds      = axi_r_valid_i & axi_r_ready_o;
   assign r_hds_last = r_hds & axi_r_last_i;

   always_comb
      begin
         state_d = state_q;
         case (state_q)
            S_BOOT:
               if (&boot_cnt_q)
                  state_d = S_IDLE;   // Last set cleared
            S_IDLE:
               if (op_inv_i)
                  state_d = S_INVALIDATE;
               else if (miss_i)
                  state_d = S_REPLACE;
            S_REPLACE:
               state_d = S_REFILL;
            S_REFILL:
               if (r_hds_last)
                  state_d = S_RELOAD;
            default:
               state_d = S_IDLE;      // Invalidate and reload take one cycle
         endcase
      end

   always_ff @(posedge clk)
      begin
         if (rst_i)
            begin
               state_q      <= S_BOOT;
               boot_cnt_q   <= '0;
               free_way_q   <= '0;
               refill_cnt_q <= '0;
            end
         else
            begin
               state_q    <= state_d;
               free_way_q <= free_way_q + way_idx_t'(1);   // Clock replacement
               if (state_q == S_BOOT)
                  boot_cnt_q <= boot_cnt_q + set_idx_t'(1);
               if (state_q != S_REFILL)
                  refill_cnt_q <= '0;
               else if (r_hds)
                  refill_cnt_q <= refill_cnt_q + BEAT_BYTES;
            end
      end

   // Stage-1 addresses kept for the reload cycle
   always_ff @(posedge clk)
      begin
         if (~stall_o)
            begin
               s1_line_q    <= line_addr_o;
               s1_payload_q <= payload_addr_o;
               inv_set_q    <= op_inv_paddr_i[`IC_P_LINE +: `IC_P_SETS];
            end
      end

   always_comb
      begin
         case (state_q)
            S_BOOT:
               line_addr_o = boot_cnt_q;
            S_INVALIDATE:
               line_addr_o = inv_set_q;
            S_RELOAD:
               line_addr_o = s1_line_q;
            S_REPLACE,
            S_REFILL:
               line_addr_o = s2_set;   // Set of the missing line
            default:
               line_addr_o = vpo_i[`IC_P_LINE +: `IC_P_SETS];
         endcase
      end

   always_comb
      begin
         case (state_q)
            S_REFILL:
               payload_addr_o = {s2_set, refill_cnt_q[`IC_P_FETCH_BYTES +: WIN_BITS]};
            S_RELOAD:
               payload_addr_o = s1_payload_q;
            default:
               payload_addr_o = vpo_i[`IC_P_FETCH_BYTES +: $bits(payload_addr_t)];
         endcase
      end

   for (genvar w = 0; w < NWAYS; w++)
      begin : gen_tag_we
         assign tag_we_o[w] = (state_q == S_BOOT) | (state_q == S_INVALIDATE) |
                              ((state_q == S_REPLACE) & (free_way_q == way_idx_t'(w)));
      end

   // Valid is only set by the replace write
   assign tag_wdata_o       = s2_paddr_i[`IC_AW-1:TAG_LSB];
   assign tag_valid_wdata_o = (state_q == S_REPLACE);

   assign payload_we_o    = r_hds;
   assign payload_wdata_o = axi_r_data_i;
   assign refill_beat_o   = r_hds;
   assign refill_off_o    = refill_cnt_q;

   assign stall_o        = (state_q != S_IDLE);
   assign op_stall_req_o = op_inv_i | stall_o;
   assign rd_en_o        = ~stall_o | (state_q == S_RELOAD);

   assign ar_set = (state_q == S_REPLACE);
   assign ar_clr = axi_ar_valid_o & axi_ar_ready_i;

   always_ff @(posedge clk)
      begin
         if (rst_i)
            axi_ar_valid_o <= 1'b0;
         else if (ar_set)
            axi_ar_valid_o <= 1'b1;
         else if (ar_clr)
            axi_ar_valid_o <= 1'b0;
      end

   always_ff @(posedge clk)
      begin
         if (ar_set)
            axi_ar_addr_o <= {s2_paddr_i[`IC_AW-1:`IC_P_LINE], {`IC_P_LINE{1'b0}}};
      end

   assign axi_r_ready_o = (state_q == S_REFILL);

endmodule

`default_nettype wire

/* hdl/ic_fetch_pipe.sv */
// Two-stage lookup pipe; a killed stage-2 lookup never shows up on valid_o
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module ic_fetch_pipe
(
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    stall_i,
   input  icache_pkg::vpo_t        vpo_i,
   input  icache_pkg::ppn_t        ppn_s2_i,
   input  logic                    kill_req_s2_i,
   input  logic                    hit_i,
   input  icache_pkg::fetch_t      hit_data_i,
   input  logic                    refill_beat_i,
   input  icache_pkg::line_off_t   refill_off_i,
   input  icache_pkg::fetch_t      refill_data_i,
   output icache_pkg::paddr_t      s2_paddr_o,
   output icache_pkg::tag_t        cmp_tag_o,
   output logic                    miss_o,
   output icache_pkg::fetch_t      ins_o,
   output logic                    valid_o
);
   import icache_pkg::*;

   localparam int TAG_LSB  = `IC_P_SETS + `IC_P_LINE;
   localparam int WIN_BITS = `IC_P_LINE - `IC_P_FETCH_BYTES;

   logic   s1_valid;
   vpo_t   s1_vpo;
   paddr_t s2i_paddr;
   logic   s2_valid;
   paddr_t s2_paddr;
   logic   refill_win_match;

   // Physical address is only complete once the PPN arrives
   assign s2i_paddr = {ppn_s2_i, s1_vpo};
   assign cmp_tag_o = s2i_paddr[`IC_AW-1:TAG_LSB];
   assign miss_o    = s1_valid & ~hit_i & ~kill_req_s2_i;

   always_ff @(posedge clk)
      begin
         if (rst_i)
            begin
               s1_valid <= 1'b0;
               s2_valid <= 1'b0;
            end
         else if (~stall_i)
            begin
               s1_valid <= 1'b1;
               s2_valid <= s1_valid & ~kill_req_s2_i;
            end
      end

   always_ff @(posedge clk)
      begin
         if (~stall_i)
            begin
               s1_vpo   <= vpo_i;
               s2_paddr <= s2i_paddr;
            end
      end

   // Bus beat carrying the requested window
   assign refill_win_match = refill_beat_i &
                             (refill_off_i[`IC_P_FETCH_BYTES +: WIN_BITS] ==
                              s2_paddr[`IC_P_FETCH_BYTES +: WIN_BITS]);

   always_ff @(posedge clk)
      begin
         if (~stall_i)
            ins_o <= hit_data_i;
         else if (refill_win_match)
            ins_o <= refill_data_i;   // Bypass while the burst is arriving
      end

   assign valid_o    = s2_valid & ~stall_i;
   assign s2_paddr_o = s2_paddr;

endmodule

`default_nettype wire

/* hdl/ic_way_array.sv */
// Per-way tag/valid and payload RAMs; data of the lowest hitting way wins on multiple hits
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module ic_way_array
(
   input  logic                        clk,
   input  logic                        rd_en_i,
   input  icache_pkg::set_idx_t        line_addr_i,
   input  icache_pkg::payload_addr_t   payload_addr_i,
   input  logic [(1<<`IC_P_WAYS)-1:0]  tag_we_i,
   input  icache_pkg::tag_t            tag_wdata_i,
   input  logic                        tag_valid_wdata_i,
   input  logic                        payload_we_i,
   input  icache_pkg::fetch_t          payload_wdata_i,
   input  icache_pkg::tag_t            cmp_tag_i,
   output logic                        hit_o,
   output icache_pkg::fetch_t          hit_data_o
);
   import icache_pkg::*;

   localparam int NWAYS    = 1 << `IC_P_WAYS;
   localparam int TAG_V_DW = $bits(tag_t) + 1;

   logic [TAG_V_DW-1:0] tag_v_q   [NWAYS];
   fetch_t              payload_q [NWAYS];
   logic [NWAYS-1:0]    way_hit;

   for (genvar w = 0; w < NWAYS; w++)
      begin : gen_way
         ic_sram #(.DW(TAG_V_DW), .AW(`IC_P_SETS)) u_tag_v_ram
            (
               .clk    (clk),
               .addr_i (line_addr_i),
               .re_i   (rd_en_i),
               .we_i   (tag_we_i[w]),
               .din_i  ({tag_wdata_i, tag_valid_wdata_i}),
               .dout_o (tag_v_q[w])
            );

         // Write enable shared by all ways
         ic_sram #(.DW(`IC_FETCH_DW), .AW($bits(payload_addr_t))) u_payload_ram
            (
               .clk    (clk),
               .addr_i (payload_addr_i),
               .re_i   (rd_en_i),
               .we_i   (payload_we_i),
               .din_i  (payload_wdata_i),
               .dout_o (payload_q[w])
            );

         assign way_hit[w] = tag_v_q[w][0] & (tag_v_q[w][TAG_V_DW-1:1] == cmp_tag_i);
      end

   assign hit_o = |way_hit;

   // Priority select, scanned downward so way 0 has the last word
   always_comb
      begin
         hit_data_o = payload_q[0];
         for (int w = NWAYS - 1; w >= 0; w--)
            if (way_hit[w])
               hit_data_o = payload_q[w];
      end

endmodule

`default_nettype wire

/* hdl/ic_sram.sv */
// Single-port RAM, one cycle read latency; a same-address write returns the old word
`timescale 1ns/1ps
`default_nettype none

module ic_sram
#(
   parameter int DW = 32,
   parameter int AW = 4
)
(
   input  logic          clk,
   input  logic [AW-1:0] addr_i,
   input  logic          re_i,
   input  logic          we_i,
   input  logic [DW-1:0] din_i,
   output logic [DW-1:0] dout_o
);

   logic [DW-1:0] mem [0:(1<<AW)-1];

   always_ff @(posedge clk)
      begin
         if (we_i)
            mem[addr_i] <= din_i;
         if (re_i)
            dout_o <= mem[addr_i];   // Holds last read while re_i is low
      end

endmodule

`default_nettype wire

/* hdl/icache_pkg.sv */
// Types for the fixed configuration; every width is derived from the macro header
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

   typedef logic [`IC_AW-1:0]                         paddr_t;
   typedef logic [`IC_P_PAGE-1:0]                     vpo_t;
   typedef logic [`IC_AW-`IC_P_PAGE-1:0]              ppn_t;
   typedef logic [`IC_AW-`IC_P_SETS-`IC_P_LINE-1:0]   tag_t;
   typedef logic [`IC_P_SETS-1:0]                     set_idx_t;
   typedef logic [`IC_P_WAYS-1:0]                     way_idx_t;
   typedef logic [`IC_P_LINE-1:0]                     line_off_t;   // Byte offset in a line

   // Set index above the window index
   typedef logic [`IC_P_SETS+`IC_P_LINE-`IC_P_FETCH_BYTES-1:0] payload_addr_t;

   typedef logic [`IC_FETCH_DW-1:0]                   fetch_t;

   // Controller states
   typedef enum logic [2:0] {
      S_BOOT,
      S_IDLE,
      S_REPLACE,
      S_REFILL,
      S_INVALIDATE,
      S_RELOAD           // Re-read stage-1 RAM addresses after a refill
   } ic_state_t;

endpackage

`default_nettype wire

/* hdl/icache_macros.svh */
// One fixed legal configuration: 2 ways, 16 sets of 32-byte lines, 64-bit bus = fetch width
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Physical address and MMU page
`define IC_AW             32
`define IC_P_PAGE         12   // Sets times line size must fit in one page

// Cache geometry, all as log2
`define IC_P_LINE         5    // 32-byte line
`define IC_P_SETS         4    // 16 sets
`define IC_P_WAYS         1    // 2 ways

// Fetch window, equal to the AXI data width
`define IC_FETCH_DW       64
`define IC_P_FETCH_BYTES  3

// Refill burst on AR/R
// INCR, ARSIZE 3, ARLEN 3, unprivileged secure data access,
// normal non-cacheable non-bufferable, id/user/qos/region/lock all zero
`define IC_BEATS          4

`endif
